/* design/alu.sv */
`timescale 1ns/100ps

module alu (
    execIf.alu                          opBus,
    output logic                        wrEn,
    output logic [isaPkg::regAddrW-1:0] wrAddr,
    output logic [isaPkg::dataW-1:0]    wrData
);
    logic [isaPkg::shamtW-1:0] shift;
    logic [isaPkg::dataW-1:0]  result;

    assign shift = opBus.srcA[isaPkg::shamtW-1:0]; // Only five bits count.

    always_comb
    begin
        result = '0;
        case (opBus.aluOp)
            aluPkg::aluAdd:  result = opBus.srcA + opBus.srcB; // Wraps, no trap.
            aluPkg::aluSub:  result = opBus.srcA - opBus.srcB;
            aluPkg::aluAnd:  result = opBus.srcA & opBus.srcB;
            aluPkg::aluOr:   result = opBus.srcA | opBus.srcB;
            aluPkg::aluXor:  result = opBus.srcA ^ opBus.srcB;
            aluPkg::aluNor:  result = ~(opBus.srcA | opBus.srcB);
            aluPkg::aluSlt:
            begin
                result[0] = ($signed(opBus.srcA) < $signed(opBus.srcB));
            end
            aluPkg::aluSltu:
            begin
                result[0] = (opBus.srcA < opBus.srcB);
            end
            aluPkg::aluSll:  result = opBus.srcB << shift;
            aluPkg::aluSrl:  result = opBus.srcB >> shift;
            aluPkg::aluSra:  result = $unsigned($signed(opBus.srcB) >>> shift);
            aluPkg::aluLui:
            begin
                result = {opBus.srcB[isaPkg::immW-1:0], {isaPkg::immW{1'b0}}};
            end
            default:         result = '0;
        endcase
    end

    // Register zero and unknown instructions never write back.
    assign wrEn   = opBus.valid && (opBus.destReg != '0) &&
                    (opBus.aluOp != aluPkg::aluZero);
    assign wrAddr = opBus.destReg;
    assign wrData = result;

endmodule

/* design/aluPkg.sv */
package aluPkg;

    // ########################################################################
    // ALU operations and immediate extension.
    // ########################################################################
    typedef enum logic [3:0] {
        aluZero = 4'd0,  // Produces nothing, never written back.
        aluAdd  = 4'd1,
        aluSub  = 4'd2,
        aluAnd  = 4'd3,
        aluOr   = 4'd4,
        aluXor  = 4'd5,
        aluNor  = 4'd6,
        aluSlt  = 4'd7,
        aluSltu = 4'd8,
        aluSll  = 4'd9,
        aluSrl  = 4'd10,
        aluSra  = 4'd11,
        aluLui  = 4'd12
    } aluOp_e;

    typedef enum logic {extZero, extSign} extKind_e;

endpackage

/* design/busPort.sv */
`timescale 1ns/100ps

module busPort (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [isaPkg::busAdrW-1:0]  wbAdr,
    input  logic [isaPkg::dataW-1:0]    wbDatW,
    input  logic [isaPkg::dataW-1:0]    busRegData,
    output logic [isaPkg::dataW-1:0]    wbDatR,
    output logic                        wbAck,
    output logic                        issueValid,
    output logic [isaPkg::dataW-1:0]    issueInstr,
    output logic [isaPkg::regAddrW-1:0] busRegAddr
);
    logic                       issueHit;
    logic                       windowHit;
    logic [isaPkg::busAdrW-1:0] windowOff;
    logic [isaPkg::dataW-1:0]   readData;
    logic                       ackNext;
    logic                       issueHold;

    // Address decode. The low two address bits select a byte and are ignored.
    assign issueHit   = (wbAdr == isaPkg::issueAddr);
    assign windowHit  = (wbAdr >= isaPkg::regWindowBase);
    assign windowOff  = wbAdr - isaPkg::regWindowBase;
    assign busRegAddr = windowOff[2 +: isaPkg::regAddrW];

    assign readData = windowHit ? busRegData : '0; // Issue address reads as zero.

    // A just-issued instruction writes back on the next edge, so the
    // acknowledge waits one cycle to let a following read see that write.
    assign ackNext = wbCyc && wbStb && !wbAck && !issueHold;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbAck     <= 1'b0;
            issueHold <= 1'b0;
        end
        else
        begin
            wbAck     <= ackNext;
            issueHold <= issueValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ackNext && !wbWe)
            wbDatR <= readData; // Valid while wbAck is high.
    end

    // The transfer is accepted on the edge that ends the wbAck cycle.
    assign issueValid = wbAck && wbCyc && wbStb && wbWe && issueHit;
    assign issueInstr = wbDatW;

endmodule

/* design/execIf.sv */
`timescale 1ns/100ps

// One decoded operation, valid for a single cycle.
interface execIf;
    logic                        valid;
    aluPkg::aluOp_e              aluOp;
    logic [isaPkg::dataW-1:0]    srcA;
    logic [isaPkg::dataW-1:0]    srcB;
    logic [isaPkg::regAddrW-1:0] destReg;

    modport decoder (
        output valid,
        output aluOp,
        output srcA,
        output srcB,
        output destReg
    );

    modport alu (
        input valid,
        input aluOp,
        input srcA,
        input srcB,
        input destReg
    );
endinterface

/* design/execTop.sv */
`timescale 1ns/100ps

module execTop (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wbCyc,
    input  logic                       wbStb,
    input  logic                       wbWe,
    input  logic [isaPkg::busAdrW-1:0] wbAdr,
    input  logic [isaPkg::dataW-1:0]   wbDatW,
    output logic [isaPkg::dataW-1:0]   wbDatR,
    output logic                       wbAck
);
    logic                        issueValid;
    logic [isaPkg::dataW-1:0]    issueInstr;
    logic [isaPkg::regAddrW-1:0] busRegAddr;
    logic [isaPkg::dataW-1:0]    busRegData;
    logic [isaPkg::regAddrW-1:0] rsAddr;
    logic [isaPkg::regAddrW-1:0] rtAddr;
    logic [isaPkg::dataW-1:0]    rsData;
    logic [isaPkg::dataW-1:0]    rtData;
    logic                        wrEn;
    logic [isaPkg::regAddrW-1:0] wrAddr;
    logic [isaPkg::dataW-1:0]    wrData;

    execIf opBus ();

    busPort uBusPort (.clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .busRegData,
                      .wbDatR, .wbAck, .issueValid, .issueInstr, .busRegAddr);

    instrDecoder uDecoder (.clk, .rst, .issueValid, .issueInstr, .rsData, .rtData,
                           .rsAddr, .rtAddr, .opBus(opBus.decoder));

    alu uAlu (.opBus(opBus.alu), .wrEn, .wrAddr, .wrData);

    // Operand, bus read and write-back ports all meet here.
    regFile uRegFile (.clk, .rst, .rsAddr, .rtAddr, .busRegAddr, .wrEn, .wrAddr, .wrData,
                      .rsData, .rtData, .busRegData);

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        issueValid,
    input  logic [isaPkg::dataW-1:0]    issueInstr,
    input  logic [isaPkg::dataW-1:0]    rsData,
    input  logic [isaPkg::dataW-1:0]    rtData,
    output logic [isaPkg::regAddrW-1:0] rsAddr,
    output logic [isaPkg::regAddrW-1:0] rtAddr,
    execIf.decoder                      opBus
);
    logic [isaPkg::opcodeW-1:0]  opcode;
    logic [isaPkg::functW-1:0]   funct;
    logic [isaPkg::regAddrW-1:0] rdAddr;
    logic [isaPkg::shamtW-1:0]   shamt;
    logic [isaPkg::immW-1:0]     imm;
    isaPkg::instrFormat_e        instrFmt;
    aluPkg::aluOp_e              aluOpNext;
    aluPkg::extKind_e            extKind;
    logic [isaPkg::dataW-1:0]    extImm;
    logic                        fixedShift;
    logic [isaPkg::dataW-1:0]    srcANext;
    logic [isaPkg::dataW-1:0]    srcBNext;
    logic [isaPkg::regAddrW-1:0] destNext;

    assign opcode = issueInstr[isaPkg::opcodeLsb +: isaPkg::opcodeW];
    assign funct  = issueInstr[0 +: isaPkg::functW];
    assign rsAddr = issueInstr[isaPkg::rsLsb +: isaPkg::regAddrW];
    assign rtAddr = issueInstr[isaPkg::rtLsb +: isaPkg::regAddrW];
    assign rdAddr = issueInstr[isaPkg::rdLsb +: isaPkg::regAddrW];
    assign shamt  = issueInstr[isaPkg::shamtLsb +: isaPkg::shamtW];
    assign imm    = issueInstr[0 +: isaPkg::immW];

    // ########################################################################
    // Format and operation.
    // ########################################################################
    always_comb
    begin
        instrFmt  = isaPkg::fmtNone;
        aluOpNext = aluPkg::aluZero;
        if (opcode == isaPkg::opRType)
        begin
            instrFmt = isaPkg::fmtR;
            case (funct)
                isaPkg::fnAdd, isaPkg::fnAddu:  aluOpNext = aluPkg::aluAdd;
                isaPkg::fnSub, isaPkg::fnSubu:  aluOpNext = aluPkg::aluSub;
                isaPkg::fnAnd:                  aluOpNext = aluPkg::aluAnd;
                isaPkg::fnOr:                   aluOpNext = aluPkg::aluOr;
                isaPkg::fnXor:                  aluOpNext = aluPkg::aluXor;
                isaPkg::fnNor:                  aluOpNext = aluPkg::aluNor;
                isaPkg::fnSlt:                  aluOpNext = aluPkg::aluSlt;
                isaPkg::fnSltu:                 aluOpNext = aluPkg::aluSltu;
                isaPkg::fnSll, isaPkg::fnSllv:  aluOpNext = aluPkg::aluSll;
                isaPkg::fnSrl, isaPkg::fnSrlv:  aluOpNext = aluPkg::aluSrl;
                isaPkg::fnSra, isaPkg::fnSrav:  aluOpNext = aluPkg::aluSra;
                default:                        instrFmt  = isaPkg::fmtNone;
            endcase
        end
        else
        begin
            instrFmt = isaPkg::fmtI;
            case (opcode)
                isaPkg::opAddi, isaPkg::opAddiu: aluOpNext = aluPkg::aluAdd;
                isaPkg::opAndi:                  aluOpNext = aluPkg::aluAnd;
                isaPkg::opOri:                   aluOpNext = aluPkg::aluOr;
                isaPkg::opXori:                  aluOpNext = aluPkg::aluXor;
                isaPkg::opSlti:                  aluOpNext = aluPkg::aluSlt;
                isaPkg::opSltiu:                 aluOpNext = aluPkg::aluSltu;
                isaPkg::opLui:                   aluOpNext = aluPkg::aluLui;
                default:                         instrFmt  = isaPkg::fmtNone;
            endcase
        end
    end

    // Logical immediates and LUI take zero extension.
    assign extKind = (opcode == isaPkg::opAndi || opcode == isaPkg::opOri ||
                      opcode == isaPkg::opXori || opcode == isaPkg::opLui) ?
                     aluPkg::extZero : aluPkg::extSign;
    assign extImm  = (extKind == aluPkg::extSign) ?
                     {{(isaPkg::dataW - isaPkg::immW){imm[isaPkg::immW-1]}}, imm} :
                     {{(isaPkg::dataW - isaPkg::immW){1'b0}}, imm};

    assign fixedShift = (instrFmt == isaPkg::fmtR) && (funct == isaPkg::fnSll ||
                        funct == isaPkg::fnSrl || funct == isaPkg::fnSra);

    always_comb
    begin
        srcANext = rsData;
        if (fixedShift)
        begin
            srcANext = '0;
            srcANext[isaPkg::shamtW-1:0] = shamt;
        end
    end

    assign srcBNext = (instrFmt == isaPkg::fmtI) ? extImm : rtData;
    assign destNext = (instrFmt == isaPkg::fmtR) ? rdAddr :
                      (instrFmt == isaPkg::fmtI) ? rtAddr : '0;

    always_ff @(posedge clk)
    begin
        if (rst)
            opBus.valid <= 1'b0;
        else
            opBus.valid <= issueValid;
    end

    always_ff @(posedge clk)
    begin
        if (issueValid)
        begin
            opBus.aluOp   <= aluOpNext;
            opBus.srcA    <= srcANext;
            opBus.srcB    <= srcBNext;
            opBus.destReg <= destNext;
        end
    end

endmodule

/* design/isaPkg.sv */
package isaPkg;

    // ########################################################################
    // Instruction word layout.
    // ########################################################################
    localparam int opcodeW   = 6;
    localparam int functW    = 6;
    localparam int regAddrW  = 5;
    localparam int shamtW    = 5;
    localparam int immW      = 16;
    localparam int dataW     = 32;
    localparam int opcodeLsb = 26;
    localparam int rsLsb     = 21;
    localparam int rtLsb     = 16;
    localparam int rdLsb     = 11;
    localparam int shamtLsb  = 6;

    // Major opcodes, R type shares opcode zero.
    localparam logic [opcodeW-1:0] opRType = 6'h00;
    localparam logic [opcodeW-1:0] opAddi  = 6'h08;
    localparam logic [opcodeW-1:0] opAddiu = 6'h09;
    localparam logic [opcodeW-1:0] opSlti  = 6'h0a;
    localparam logic [opcodeW-1:0] opSltiu = 6'h0b;
    localparam logic [opcodeW-1:0] opAndi  = 6'h0c;
    localparam logic [opcodeW-1:0] opOri   = 6'h0d;
    localparam logic [opcodeW-1:0] opXori  = 6'h0e;
    localparam logic [opcodeW-1:0] opLui   = 6'h0f;

    localparam logic [functW-1:0] fnSll  = 6'h00;
    localparam logic [functW-1:0] fnSrl  = 6'h02;
    localparam logic [functW-1:0] fnSra  = 6'h03;
    localparam logic [functW-1:0] fnSllv = 6'h04;
    localparam logic [functW-1:0] fnSrlv = 6'h06;
    localparam logic [functW-1:0] fnSrav = 6'h07;
    localparam logic [functW-1:0] fnAdd  = 6'h20;
    localparam logic [functW-1:0] fnAddu = 6'h21;
    localparam logic [functW-1:0] fnSub  = 6'h22;
    localparam logic [functW-1:0] fnSubu = 6'h23;
    localparam logic [functW-1:0] fnAnd  = 6'h24;
    localparam logic [functW-1:0] fnOr   = 6'h25;
    localparam logic [functW-1:0] fnXor  = 6'h26;
    localparam logic [functW-1:0] fnNor  = 6'h27;
    localparam logic [functW-1:0] fnSlt  = 6'h2a;
    localparam logic [functW-1:0] fnSltu = 6'h2b;

    typedef enum logic [1:0] {fmtR, fmtI, fmtNone} instrFormat_e;

    // ########################################################################
    // Bus address map.
    // ########################################################################
    localparam int busAdrW = 8;
    localparam logic [busAdrW-1:0] issueAddr     = 8'h00;
    localparam logic [busAdrW-1:0] regWindowBase = 8'h80; // Register i at base + 4*i.

endpackage

/* design/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [isaPkg::regAddrW-1:0] rsAddr,
    input  logic [isaPkg::regAddrW-1:0] rtAddr,
    input  logic [isaPkg::regAddrW-1:0] busRegAddr,
    input  logic                        wrEn,
    input  logic [isaPkg::regAddrW-1:0] wrAddr,
    input  logic [isaPkg::dataW-1:0]    wrData,
    output logic [isaPkg::dataW-1:0]    rsData,
    output logic [isaPkg::dataW-1:0]    rtData,
    output logic [isaPkg::dataW-1:0]    busRegData
);
    logic [isaPkg::dataW-1:0] regs [1:31]; // No storage behind register zero.

    function automatic logic [isaPkg::dataW-1:0] readReg(
        input logic [isaPkg::regAddrW-1:0] addr
    );
        readReg = (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrAddr != '0)
            regs[wrAddr] <= wrData;
    end

    assign rsData     = readReg(rsAddr);
    assign rtData     = readReg(rtAddr);
    assign busRegData = readReg(busRegAddr);

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
verilator --binary --timing --assert --top-module tbExec -f verilog.f -o simExec \
    && ./obj_dir/simExec > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run error."; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "Simulation FAILED."; exit 1; } \
    || { echo "Simulation OK."; exit 0; }

/* sim/tbExec.sv */
`timescale 1ns/100ps

module tbExec;
    localparam int plannedTransfers = 220;
    localparam int cycleLimit = 40 * plannedTransfers; // Generous per transfer.

    logic clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [isaPkg::busAdrW-1:0] wbAdr;
    logic [isaPkg::dataW-1:0] wbDatW;
    logic [isaPkg::dataW-1:0] wbDatR;
    logic wbAck;

    logic [31:0] model [32];
    logic [31:0] lfsr = 32'he5b6_c4ab;
    logic [31:0] rdData;
    int checkCount = 0;
    int failCount = 0;
    int checksAtStart = 0;
    int failsAtStart = 0;
    int cycles = 0;
    logic [5:0] immOps [8] = '{isaPkg::opLui, isaPkg::opOri, isaPkg::opAndi, isaPkg::opXori,
                               isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu};
    logic [5:0] arithFns [8] = '{isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub, isaPkg::fnSubu,
                                 isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor};
    logic [5:0] shiftFns [6] = '{isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra,
                                 isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav};

    execTop uut (.clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering the bus.", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ########################################################################
    // Checks, random numbers and instruction words.
    // ########################################################################
    task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
            failCount++;
        end
    endtask

    task automatic checkCond(input string what, input bit ok);
        checkCount++;
        assert (ok)
        else
        begin
            $display("Check broken at %0t ns: %s did not hold.", $time, what);
            failCount++;
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input int rs, input int rt,
                                          input int rd, input logic [4:0] sh);
        return {isaPkg::opRType, 5'(rs), 5'(rt), 5'(rd), sh, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [7:0] regAdr(input int r);
        return isaPkg::regWindowBase + 8'(4 * r);
    endfunction

    // Reference model of one instruction, straight from the ISA rules.
    task automatic applyModel(input logic [31:0] instr);
        logic [5:0] op;
        logic [4:0] rd;
        logic [4:0] sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] res;
        logic [4:0] dest;
        bit known;
        op = instr[31:26];
        rd = instr[15:11];
        sh = instr[10:6];
        a = model[instr[25:21]];
        b = model[instr[20:16]];
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0, instr[15:0]};
        dest = instr[20:16];
        known = 1'b1;
        res = '0;
        if (op == isaPkg::opRType)
        begin
            dest = rd;
            case (instr[5:0])
                isaPkg::fnSll:                 res = b << sh;
                isaPkg::fnSrl:                 res = b >> sh;
                isaPkg::fnSra:                 res = $unsigned($signed(b) >>> sh);
                isaPkg::fnSllv:                res = b << a[4:0];
                isaPkg::fnSrlv:                res = b >> a[4:0];
                isaPkg::fnSrav:                res = $unsigned($signed(b) >>> a[4:0]);
                isaPkg::fnAdd, isaPkg::fnAddu: res = a + b;
                isaPkg::fnSub, isaPkg::fnSubu: res = a - b;
                isaPkg::fnAnd:                 res = a & b;
                isaPkg::fnOr:                  res = a | b;
                isaPkg::fnXor:                 res = a ^ b;
                isaPkg::fnNor:                 res = ~(a | b);
                isaPkg::fnSlt:                 res = {31'b0, $signed(a) < $signed(b)};
                isaPkg::fnSltu:                res = {31'b0, a < b};
                default:                       known = 1'b0;
            endcase
        end
        else
        begin
            case (op)
                isaPkg::opAddi, isaPkg::opAddiu: res = a + sImm;
                isaPkg::opSlti:                  res = {31'b0, $signed(a) < $signed(sImm)};
                isaPkg::opSltiu:                 res = {31'b0, a < sImm};
                isaPkg::opAndi:                  res = a & zImm;
                isaPkg::opOri:                   res = a | zImm;
                isaPkg::opXori:                  res = a ^ zImm;
                isaPkg::opLui:                   res = {instr[15:0], 16'h0};
                default:                         known = 1'b0;
            endcase
        end
        if (known && dest != 5'd0)
            model[dest] = res;
    endtask

    // ########################################################################
    // Wishbone host side.
    // ########################################################################
    task automatic busAccess(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int latency;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = wdat;
        @(posedge clk);
        #2;
        latency = 1;
        while (!wbAck)
        begin
            @(posedge clk);
            #2;
            latency++;
        end
        checkCond("wbAck one cycle after strobe", latency == 1);
        rdat = wbDatR;
        @(posedge clk); // Accept edge.
        #2;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        checkCond("wbAck low after accept", !wbAck);
        @(posedge clk);
        #2;
    endtask

    task automatic busWrite(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        busAccess(1'b1, adr, dat, unused);
    endtask

    task automatic busRead(input logic [7:0] adr, output logic [31:0] dat);
        busAccess(1'b0, adr, '0, dat);
    endtask

    task automatic exec(input logic [31:0] instr);
        busWrite(isaPkg::issueAddr, instr);
        applyModel(instr);
    endtask

    task automatic loadReg(input int r, input logic [31:0] v);
        exec(iType(isaPkg::opLui, 0, r, v[31:16]));
        exec(iType(isaPkg::opOri, r, r, v[15:0]));
    endtask

    task automatic checkReg(input int r);
        logic [31:0] d;
        busRead(regAdr(r), d);
        checkValue($sformatf("register r%0d", r), d, model[r]);
    endtask

    task automatic endTest(input string name);
        $display("%s finished, %0d checks, %0d failed", name, checkCount - checksAtStart,
                 failCount - failsAtStart);
        checksAtStart = checkCount;
        failsAtStart = failCount;
    endtask

    // ########################################################################
    // Test sequence.
    // ########################################################################
    initial
    begin
        logic [15:0] imm;
        logic [31:0] sltVal;
        logic [31:0] sltuVal;
        rst = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        for (int r = 0; r < 32; r++)
            model[r] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        checkCond("wbAck low after reset", !wbAck);
        for (int r = 0; r < 32; r++)
            checkReg(r);
        endTest("Reset and handshake");

        for (int r = 1; r <= 8; r++)
        begin
            loadReg(r, randBits(32));
            checkReg(r);
        end
        for (int i = 0; i < 16; i++)
        begin
            imm = 16'(randBits(16));
            if (i >= 8)
                imm[15] = 1'b1; // Second round uses negative immediates.
            exec(iType(immOps[i % 8], 1 + i % 8, 9 + i, imm));
            checkReg(9 + i);
        end
        endTest("Immediate operations");

        for (int i = 0; i < 16; i++)
        begin
            exec(rType(arithFns[i % 8], 1 + int'(randBits(3)), 1 + int'(randBits(3)),
                       9 + i, 5'd0));
            checkReg(9 + i);
        end
        loadReg(20, 32'h7fff_ffff);
        loadReg(22, 32'h8000_0000);
        exec(rType(isaPkg::fnAdd, 20, 20, 21, 5'd0)); // Signed overflow wraps.
        checkReg(21);
        exec(rType(isaPkg::fnSub, 22, 20, 23, 5'd0));
        checkReg(23);
        endTest("R-type arithmetic and logic");

        repeat (4)
        begin
            loadReg(24, randBits(32) | 32'h8000_0000);
            loadReg(25, randBits(32) & 32'h7fff_ffff);
            exec(rType(isaPkg::fnSlt, 24, 25, 26, 5'd0));
            exec(rType(isaPkg::fnSltu, 24, 25, 27, 5'd0));
            busRead(regAdr(26), sltVal);
            busRead(regAdr(27), sltuVal);
            checkValue("register r26", sltVal, model[26]);
            checkValue("register r27", sltuVal, model[27]);
            checkCond("SLT and SLTU disagree on mixed signs", sltVal != sltuVal);
        end
        endTest("Comparisons");

        loadReg(28, randBits(32) | 32'h8000_0000);
        loadReg(29, randBits(32));
        for (int i = 0; i < 6; i++)
        begin
            if (i < 3)
                exec(rType(shiftFns[i], 0, 28, 30, 5'(randBits(5))));
            else
                exec(rType(shiftFns[i], 29, 28, 30, 5'd0));
            checkReg(30);
        end
        exec(rType(isaPkg::fnSra, 0, 28, 31, 5'd4));
        busRead(regAdr(31), rdData);
        checkValue("register r31", rdData, model[31]);
        checkCond("SRA of a negative value fills with ones", rdData[31:27] == 5'h1f);
        endTest("Shifts");

        exec(iType(isaPkg::opAddiu, 1, 0, 16'h0005));
        checkReg(0);
        exec(rType(isaPkg::fnOr, 1, 2, 0, 5'd0));
        checkReg(0);
        exec(32'hfc00_0000 | randBits(26)); // Opcode 0x3f is not supported.
        for (int r = 0; r < 32; r++)
            checkReg(r);
        busWrite(regAdr(5), ~model[5]);
        checkReg(5);
        busRead(isaPkg::issueAddr, rdData);
        checkValue("issue address", rdData, 32'h0);
        endTest("Protected state");

        $display("%0d checks passed, %0d failed", checkCount - failCount, failCount);
        if (failCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* verilog.f */
design/isaPkg.sv
design/aluPkg.sv
design/execIf.sv
design/busPort.sv
design/instrDecoder.sv
design/alu.sv
design/regFile.sv
design/execTop.sv
sim/tbExec.sv
